// File: hw/xm_types_pkg.sv
/*
 * Data and address types for the host register interface.
 * Shared by the memory channels and the bus read path.
 */
`default_nettype none

package xm_types_pkg;

    localparam int WORD_W = 16;                // register and memory word width

    typedef logic [7:0]        byte_t;         // one host bus byte
    typedef logic [WORD_W-1:0] word_t;         // register or memory data word
    typedef logic [WORD_W-1:0] addr_t;         // memory address
    typedef logic [3:0]        wrmask_t;       // vram nibble write mask

    // register word written by byte and read as a word
    typedef union packed {
        word_t w;
        struct packed {
            byte_t hi;                         // even byte, bytesel 0
            byte_t lo;                         // odd byte, bytesel 1
        } b;
    } reg_word_u;

endpackage

`default_nettype wire

// File: hw/xm_regmap_pkg.sv
/*
 * Register map of the host register interface.
 * Register numbers, status word bit positions and reset values.
 */
`default_nettype none

package xm_regmap_pkg;

    typedef logic [3:0] reg_num_t;

    localparam reg_num_t XM_SYS_CTRL = 4'h0;   // status and write mask
    localparam reg_num_t XM_INT_CTRL = 4'h1;   // reads as zero
    localparam reg_num_t XM_TIMER    = 4'h2;   // reads as zero
    localparam reg_num_t XM_RD_XADDR = 4'h3;
    localparam reg_num_t XM_WR_XADDR = 4'h4;
    localparam reg_num_t XM_XDATA    = 4'h5;
    localparam reg_num_t XM_RD_INCR  = 4'h6;
    localparam reg_num_t XM_RD_ADDR  = 4'h7;
    localparam reg_num_t XM_WR_INCR  = 4'h8;
    localparam reg_num_t XM_WR_ADDR  = 4'h9;
    localparam reg_num_t XM_DATA     = 4'hA;
    localparam reg_num_t XM_DATA_2   = 4'hB;

    // status word bits with the write mask in bits 3:0
    localparam int STAT_MEM_WAIT = 15;
    localparam int STAT_HBLANK   = 11;
    localparam int STAT_VBLANK   = 10;

    localparam logic [3:0] WRMASK_RESET = 4'hF;

endpackage

`default_nettype wire

// File: hw/bus_strobe_sync.sv
/*
 * Host bus synchronizer.
 * Samples the asynchronous chip select, detects its falling edge and
 * issues one read or write strobe per access with the latched bus fields.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_strobe_sync (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    cs_n_i,
    input  wire logic                    rd_nwr_i,       // 1 = read
    input  wire xm_regmap_pkg::reg_num_t reg_num_i,
    input  wire logic                    bytesel_i,
    input  wire xm_types_pkg::byte_t     data_i,
    output      logic                    write_strobe_o,
    output      logic                    read_strobe_o,
    output      xm_regmap_pkg::reg_num_t reg_num_o,
    output      logic                    bytesel_o,
    output      xm_types_pkg::byte_t     data_o
);

    logic cs_meta;                          // first sync stage
    logic cs_sync;                          // second sync stage
    logic cs_prev;                          // for edge detect
    logic cs_fall;

    assign cs_fall = cs_prev & ~cs_sync;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_meta        <= 1'b1;
            cs_sync        <= 1'b1;
            cs_prev        <= 1'b1;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
        end else begin
            cs_meta        <= cs_n_i;
            cs_sync        <= cs_meta;
            cs_prev        <= cs_sync;
            write_strobe_o <= cs_fall & ~rd_nwr_i;
            read_strobe_o  <= cs_fall & rd_nwr_i;
        end
    end

    // bus fields are stable by the time the edge is seen
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            reg_num_o <= reg_num_i;
            bytesel_o <= bytesel_i;
            data_o    <= data_i;
        end
    end

    // host keeps the bus fields steady while chip select stays low
    bus_held_while_cs: assert property (@(posedge clk) disable iff (reset_i)
        !cs_n_i && !$past(cs_n_i) |-> $stable({rd_nwr_i, reg_num_i, bytesel_i, data_i}));

endmodule

`default_nettype wire

// File: hw/vram_channel.sv
/*
 * VRAM channel.
 * Holds the VRAM address, increment, data and write mask registers,
 * issues write and pre-read requests and steps the addresses on ack.
 */
`timescale 1ns/10ps
`default_nettype none

module vram_channel (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    write_strobe_i,
    input  wire logic                    read_strobe_i,
    input  wire xm_regmap_pkg::reg_num_t reg_num_i,
    input  wire logic                    bytesel_i,
    input  wire xm_types_pkg::byte_t     data_i,
    input  wire logic                    vram_ack_i,
    input  wire xm_types_pkg::word_t     vram_data_i,
    output      logic                    vram_sel_o,
    output      logic                    vram_wr_o,
    output      xm_types_pkg::addr_t     vram_addr_o,
    output      xm_types_pkg::word_t     vram_data_o,
    output      xm_types_pkg::wrmask_t   vram_wrmask_o,
    output      xm_types_pkg::reg_word_u rd_incr_o,
    output      xm_types_pkg::reg_word_u rd_addr_o,
    output      xm_types_pkg::reg_word_u wr_incr_o,
    output      xm_types_pkg::reg_word_u wr_addr_o,
    output      xm_types_pkg::word_t     data_o,
    output      logic                    busy_o
);

    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    byte_t data_even;                       // held even byte of DATA
    logic  data_reg;                        // DATA or DATA_2 addressed

    assign data_reg = (reg_num_i == XM_DATA) || (reg_num_i == XM_DATA_2);
    assign busy_o   = vram_sel_o;           // read or write outstanding

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o    <= 1'b0;
            vram_wr_o     <= 1'b0;
            vram_addr_o   <= '0;
            vram_wrmask_o <= WRMASK_RESET;
            rd_incr_o     <= '0;
            rd_addr_o     <= '0;
            wr_incr_o     <= '0;
            wr_addr_o     <= '0;
            data_o        <= '0;
        end else begin
            if (vram_ack_i) begin
                if (vram_wr_o) begin
                    wr_addr_o.w <= wr_addr_o.w + wr_incr_o.w;
                end else begin
                    data_o      <= vram_data_i;        // pre-read result
                    rd_addr_o.w <= rd_addr_o.w + rd_incr_o.w;
                end
                vram_sel_o <= 1'b0;
                vram_wr_o  <= 1'b0;
            end

            if (write_strobe_i) begin
                case (reg_num_i)
                    XM_SYS_CTRL: if (bytesel_i) vram_wrmask_o <= data_i[3:0];
                    XM_RD_INCR:  if (bytesel_i) rd_incr_o.b.lo <= data_i;
                                 else           rd_incr_o.b.hi <= data_i;
                    XM_WR_INCR:  if (bytesel_i) wr_incr_o.b.lo <= data_i;
                                 else           wr_incr_o.b.hi <= data_i;
                    XM_WR_ADDR:  if (bytesel_i) wr_addr_o.b.lo <= data_i;
                                 else           wr_addr_o.b.hi <= data_i;
                    XM_RD_ADDR: begin
                        if (bytesel_i) begin
                            rd_addr_o.b.lo <= data_i;
                            vram_sel_o     <= 1'b1;
                            vram_wr_o      <= 1'b0;
                            vram_addr_o    <= {rd_addr_o.b.hi, data_i};
                        end else begin
                            rd_addr_o.b.hi <= data_i;
                        end
                    end
                    XM_DATA, XM_DATA_2: begin
                        if (bytesel_i) begin
                            vram_sel_o  <= 1'b1;       // replaces any pending request
                            vram_wr_o   <= 1'b1;
                            vram_addr_o <= wr_addr_o.w;
                        end
                    end
                    default: ;
                endcase
            end

            // odd byte of DATA read starts the next fetch
            if (read_strobe_i && bytesel_i && data_reg) begin
                vram_sel_o  <= 1'b1;
                vram_wr_o   <= 1'b0;
                vram_addr_o <= rd_addr_o.w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_strobe_i && data_reg) begin
            if (bytesel_i) begin
                vram_data_o <= {data_even, data_i};
            end else begin
                data_even   <= data_i;
            end
        end
    end

    ack_while_sel: assert property (@(posedge clk) disable iff (reset_i)
        vram_ack_i |-> vram_sel_o);
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        vram_ack_i |=> !vram_ack_i);

endmodule

`default_nettype wire

// File: hw/xr_channel.sv
/*
 * XR channel.
 * Holds the XR read and write addresses and the XDATA latch, issues
 * write and pre-read requests and steps both addresses by one on ack.
 */
`timescale 1ns/10ps
`default_nettype none

module xr_channel (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    write_strobe_i,
    input  wire logic                    read_strobe_i,
    input  wire xm_regmap_pkg::reg_num_t reg_num_i,
    input  wire logic                    bytesel_i,
    input  wire xm_types_pkg::byte_t     data_i,
    input  wire logic                    xr_ack_i,
    input  wire xm_types_pkg::word_t     xr_data_i,
    output      logic                    xr_sel_o,
    output      logic                    xr_wr_o,
    output      xm_types_pkg::addr_t     xr_addr_o,
    output      xm_types_pkg::word_t     xr_data_o,
    output      xm_types_pkg::reg_word_u rd_xaddr_o,
    output      xm_types_pkg::reg_word_u wr_xaddr_o,
    output      xm_types_pkg::word_t     xdata_o,
    output      logic                    busy_o
);

    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    byte_t xdata_even;                      // held even byte of XDATA

    assign busy_o = xr_sel_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_sel_o   <= 1'b0;
            xr_wr_o    <= 1'b0;
            xr_addr_o  <= '0;
            rd_xaddr_o <= '0;
            wr_xaddr_o <= '0;
            xdata_o    <= '0;
        end else begin
            if (xr_ack_i) begin
                if (xr_wr_o) begin
                    wr_xaddr_o.w <= wr_xaddr_o.w + 1'b1;
                end else begin
                    xdata_o      <= xr_data_i;
                    rd_xaddr_o.w <= rd_xaddr_o.w + 1'b1;
                end
                xr_sel_o <= 1'b0;
                xr_wr_o  <= 1'b0;
            end

            if (write_strobe_i) begin
                case (reg_num_i)
                    XM_RD_XADDR: begin
                        if (bytesel_i) begin
                            rd_xaddr_o.b.lo <= data_i;
                            xr_sel_o        <= 1'b1;   // pre-read at new address
                            xr_wr_o         <= 1'b0;
                            xr_addr_o       <= {rd_xaddr_o.b.hi, data_i};
                        end else begin
                            rd_xaddr_o.b.hi <= data_i;
                        end
                    end
                    XM_WR_XADDR: if (bytesel_i) wr_xaddr_o.b.lo <= data_i;
                                 else           wr_xaddr_o.b.hi <= data_i;
                    XM_XDATA: begin
                        if (bytesel_i) begin
                            xr_sel_o  <= 1'b1;
                            xr_wr_o   <= 1'b1;
                            xr_addr_o <= wr_xaddr_o.w;
                        end
                    end
                    default: ;
                endcase
            end

            if (read_strobe_i && bytesel_i && reg_num_i == XM_XDATA) begin
                xr_sel_o  <= 1'b1;
                xr_wr_o   <= 1'b0;
                xr_addr_o <= rd_xaddr_o.w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_strobe_i && reg_num_i == XM_XDATA) begin
            if (bytesel_i) begin
                xr_data_o  <= {xdata_even, data_i};
            end else begin
                xdata_even <= data_i;
            end
        end
    end

    ack_while_sel: assert property (@(posedge clk) disable iff (reset_i)
        xr_ack_i |-> xr_sel_o);

endmodule

`default_nettype wire

// File: hw/reg_read_mux.sv
/*
 * Bus read multiplexer.
 * Builds the status word and returns the addressed byte of the selected
 * register word to the host.
 */
`timescale 1ns/10ps
`default_nettype none

module reg_read_mux (
    input  wire xm_regmap_pkg::reg_num_t reg_num_i,
    input  wire logic                    bytesel_i,
    input  wire logic                    h_blank_i,
    input  wire logic                    v_blank_i,
    input  wire logic                    vram_busy_i,
    input  wire logic                    xr_busy_i,
    input  wire xm_types_pkg::wrmask_t   vram_wrmask_i,
    input  wire xm_types_pkg::reg_word_u rd_incr_i,
    input  wire xm_types_pkg::reg_word_u rd_addr_i,
    input  wire xm_types_pkg::reg_word_u wr_incr_i,
    input  wire xm_types_pkg::reg_word_u wr_addr_i,
    input  wire xm_types_pkg::word_t     data_i,
    input  wire xm_types_pkg::reg_word_u rd_xaddr_i,
    input  wire xm_types_pkg::reg_word_u wr_xaddr_i,
    input  wire xm_types_pkg::word_t     xdata_i,
    output      xm_types_pkg::byte_t     bus_data_o
);

    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    word_t     status;
    reg_word_u rd_word;

    always_comb begin
        status                = '0;
        status[STAT_MEM_WAIT] = vram_busy_i | xr_busy_i;
        status[STAT_HBLANK]   = h_blank_i;
        status[STAT_VBLANK]   = v_blank_i;
        status[3:0]           = vram_wrmask_i;
    end

    always_comb begin
        case (reg_num_i)
            XM_SYS_CTRL:        rd_word.w = status;
            XM_INT_CTRL,
            XM_TIMER:           rd_word.w = '0;
            XM_RD_XADDR:        rd_word   = rd_xaddr_i;
            XM_WR_XADDR:        rd_word   = wr_xaddr_i;
            XM_XDATA:           rd_word.w = xdata_i;
            XM_RD_INCR:         rd_word   = rd_incr_i;
            XM_RD_ADDR:         rd_word   = rd_addr_i;
            XM_WR_INCR:         rd_word   = wr_incr_i;
            XM_WR_ADDR:         rd_word   = wr_addr_i;
            XM_DATA, XM_DATA_2: rd_word.w = data_i;
            default:            rd_word.w = '0;   // 0xC to 0xF
        endcase
    end

    assign bus_data_o = bytesel_i ? rd_word.b.lo : rd_word.b.hi;

endmodule

`default_nettype wire

// File: hw/xm_reg_interface.sv
/*
 * Host register interface of the video controller.
 * Connects the bus synchronizer, the VRAM and XR channels and the
 * bus read multiplexer.
 */
`timescale 1ns/10ps
`default_nettype none

module xm_reg_interface (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    cs_n_i,
    input  wire logic                    rd_nwr_i,
    input  wire xm_regmap_pkg::reg_num_t reg_num_i,
    input  wire logic                    bytesel_i,
    input  wire xm_types_pkg::byte_t     bus_data_i,
    output      xm_types_pkg::byte_t     bus_data_o,
    input  wire logic                    h_blank_i,
    input  wire logic                    v_blank_i,
    input  wire logic                    vram_ack_i,
    input  wire xm_types_pkg::word_t     vram_data_i,
    output      logic                    vram_sel_o,
    output      logic                    vram_wr_o,
    output      xm_types_pkg::addr_t     vram_addr_o,
    output      xm_types_pkg::word_t     vram_data_o,
    output      xm_types_pkg::wrmask_t   vram_wrmask_o,
    input  wire logic                    xr_ack_i,
    input  wire xm_types_pkg::word_t     xr_data_i,
    output      logic                    xr_sel_o,
    output      logic                    xr_wr_o,
    output      xm_types_pkg::addr_t     xr_addr_o,
    output      xm_types_pkg::word_t     xr_data_o
);

    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    logic      write_strobe;
    logic      read_strobe;
    reg_num_t  reg_num;
    logic      bytesel;
    byte_t     data_byte;

    reg_word_u rd_incr, rd_addr, wr_incr, wr_addr;
    reg_word_u rd_xaddr, wr_xaddr;
    word_t     vram_word, xdata;
    logic      vram_busy, xr_busy;

    bus_strobe_sync u_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .cs_n_i         (cs_n_i),
        .rd_nwr_i       (rd_nwr_i),
        .reg_num_i      (reg_num_i),
        .bytesel_i      (bytesel_i),
        .data_i         (bus_data_i),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .bytesel_o      (bytesel),
        .data_o         (data_byte)
    );

    vram_channel u_vram (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .reg_num_i      (reg_num),
        .bytesel_i      (bytesel),
        .data_i         (data_byte),
        .vram_ack_i     (vram_ack_i),
        .vram_data_i    (vram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_wr_o      (vram_wr_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_o    (vram_data_o),
        .vram_wrmask_o  (vram_wrmask_o),
        .rd_incr_o      (rd_incr),
        .rd_addr_o      (rd_addr),
        .wr_incr_o      (wr_incr),
        .wr_addr_o      (wr_addr),
        .data_o         (vram_word),
        .busy_o         (vram_busy)
    );

    xr_channel u_xr (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .reg_num_i      (reg_num),
        .bytesel_i      (bytesel),
        .data_i         (data_byte),
        .xr_ack_i       (xr_ack_i),
        .xr_data_i      (xr_data_i),
        .xr_sel_o       (xr_sel_o),
        .xr_wr_o        (xr_wr_o),
        .xr_addr_o      (xr_addr_o),
        .xr_data_o      (xr_data_o),
        .rd_xaddr_o     (rd_xaddr),
        .wr_xaddr_o     (wr_xaddr),
        .xdata_o        (xdata),
        .busy_o         (xr_busy)
    );

    reg_read_mux u_rd_mux (
        .reg_num_i      (reg_num),
        .bytesel_i      (bytesel),
        .h_blank_i      (h_blank_i),
        .v_blank_i      (v_blank_i),
        .vram_busy_i    (vram_busy),
        .xr_busy_i      (xr_busy),
        .vram_wrmask_i  (vram_wrmask_o),
        .rd_incr_i      (rd_incr),
        .rd_addr_i      (rd_addr),
        .wr_incr_i      (wr_incr),
        .wr_addr_i      (wr_addr),
        .data_i         (vram_word),
        .rd_xaddr_i     (rd_xaddr),
        .wr_xaddr_i     (wr_xaddr),
        .xdata_i        (xdata),
        .bus_data_o     (bus_data_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_mem_model.sv
/*
 * VRAM and XR memory models for the register interface testbench.
 * Each port acks a request after a programmable number of cycles.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [7:0]            ack_delay_i,    // cycles from sel to ack
    input  wire logic                  vram_sel_i,
    input  wire logic                  vram_wr_i,
    input  wire xm_types_pkg::addr_t   vram_addr_i,
    input  wire xm_types_pkg::word_t   vram_data_i,
    input  wire xm_types_pkg::wrmask_t vram_wrmask_i,
    output      logic                  vram_ack_o,
    output      xm_types_pkg::word_t   vram_data_o,
    input  wire logic                  xr_sel_i,
    input  wire logic                  xr_wr_i,
    input  wire xm_types_pkg::addr_t   xr_addr_i,
    input  wire xm_types_pkg::word_t   xr_data_i,
    output      logic                  xr_ack_o,
    output      xm_types_pkg::word_t   xr_data_o
);

    import xm_types_pkg::*;

    word_t      vram_mem [0:255];
    word_t      xr_mem [0:255];
    logic [7:0] vram_cnt;
    logic [7:0] xr_cnt;
    word_t      nib_mask;                  // write mask widened to bits
    word_t      vram_merged;

    assign nib_mask = {{4{vram_wrmask_i[3]}}, {4{vram_wrmask_i[2]}},
                       {4{vram_wrmask_i[1]}}, {4{vram_wrmask_i[0]}}};
    assign vram_merged = (vram_mem[vram_addr_i[7:0]] & ~nib_mask) | (vram_data_i & nib_mask);

    initial begin
        for (int i = 0; i < 256; i++) begin
            vram_mem[i] = '0;
            xr_mem[i]   = '0;
        end
    end

    always @(posedge clk) begin
        if (reset_i) begin
            vram_ack_o <= 1'b0;
            vram_cnt   <= '0;
        end else if (vram_ack_o) begin
            vram_ack_o <= 1'b0;            // one cycle pulse
            vram_cnt   <= '0;
        end else if (vram_sel_i) begin
            if (vram_cnt >= ack_delay_i) begin
                vram_ack_o <= 1'b1;
                if (vram_wr_i) begin
                    vram_mem[vram_addr_i[7:0]] <= vram_merged;
                end else begin
                    vram_data_o <= vram_mem[vram_addr_i[7:0]];
                end
            end else begin
                vram_cnt <= vram_cnt + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (reset_i) begin
            xr_ack_o <= 1'b0;
            xr_cnt   <= '0;
        end else if (xr_ack_o) begin
            xr_ack_o <= 1'b0;
            xr_cnt   <= '0;
        end else if (xr_sel_i) begin
            if (xr_cnt >= ack_delay_i) begin
                xr_ack_o <= 1'b1;
                if (xr_wr_i) begin
                    xr_mem[xr_addr_i[7:0]] <= xr_data_i;
                end else begin
                    xr_data_o <= xr_mem[xr_addr_i[7:0]];
                end
            end else begin
                xr_cnt <= xr_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_reg_interface.sv
/*
 * Testbench for the host register interface.
 * Replays bus operations from a trace file against the DUT and the
 * memory models and compares every read byte with the trace.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_reg_interface;

    import xm_types_pkg::*;
    import xm_regmap_pkg::*;

    localparam int CYCLES_PER_LINE = 40;

    logic       clk;
    logic       reset_i;
    logic       cs_n;
    logic       rd_nwr;
    reg_num_t   reg_num;
    logic       bytesel;
    byte_t      bus_wdata;
    byte_t      bus_rdata;
    logic       h_blank;
    logic       v_blank;
    logic [7:0] ack_delay;
    logic       vram_ack, vram_sel, vram_wr;
    word_t      vram_rdata, vram_wdata;
    addr_t      vram_addr;
    wrmask_t    vram_wrmask;
    logic       xr_ack, xr_sel, xr_wr;
    word_t      xr_rdata, xr_wdata;
    addr_t      xr_addr;

    logic [8*96-1:0] trace_lines [$];
    logic [8*32-1:0] test_name;
    logic            test_open;
    logic            trace_ok;
    int cycle_count, cycle_limit;
    int test_count, check_count, error_count, test_errors, test_checks;

    xm_reg_interface dut (
        .clk (clk), .reset_i (reset_i),
        .cs_n_i (cs_n), .rd_nwr_i (rd_nwr), .reg_num_i (reg_num),
        .bytesel_i (bytesel), .bus_data_i (bus_wdata), .bus_data_o (bus_rdata),
        .h_blank_i (h_blank), .v_blank_i (v_blank),
        .vram_ack_i (vram_ack), .vram_data_i (vram_rdata), .vram_sel_o (vram_sel),
        .vram_wr_o (vram_wr), .vram_addr_o (vram_addr), .vram_data_o (vram_wdata),
        .vram_wrmask_o (vram_wrmask),
        .xr_ack_i (xr_ack), .xr_data_i (xr_rdata), .xr_sel_o (xr_sel),
        .xr_wr_o (xr_wr), .xr_addr_o (xr_addr), .xr_data_o (xr_wdata)
    );

    tb_mem_model u_mem (
        .clk (clk), .reset_i (reset_i), .ack_delay_i (ack_delay),
        .vram_sel_i (vram_sel), .vram_wr_i (vram_wr), .vram_addr_i (vram_addr),
        .vram_data_i (vram_wdata), .vram_wrmask_i (vram_wrmask),
        .vram_ack_o (vram_ack), .vram_data_o (vram_rdata),
        .xr_sel_i (xr_sel), .xr_wr_i (xr_wr), .xr_addr_i (xr_addr),
        .xr_data_i (xr_wdata), .xr_ack_o (xr_ack), .xr_data_o (xr_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the trace did not finish", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // one host access with chip select low for eight cycles
    task automatic bus_access(input logic rd, input reg_num_t rn, input logic bs,
                              input byte_t wdata, input logic [7:0] dly, output byte_t rdata);
        @(posedge clk);
        #5;
        ack_delay = dly;
        cs_n      = 1'b0;
        rd_nwr    = rd;
        reg_num   = rn;
        bytesel   = bs;
        bus_wdata = wdata;
        repeat (7) @(posedge clk);
        @(negedge clk);
        rdata = bus_rdata;                 // last cycle of the window
        @(posedge clk);
        #5;
        cs_n = 1'b1;
        repeat (2) @(posedge clk);         // let the synchronizer see cs high
    endtask

    task automatic check_byte(input reg_num_t rn, input logic bs, input byte_t got,
                              input byte_t exp);
        check_count++;
        test_checks++;
        assert (got === exp) else begin
            $display("Fail %0s: bus_data_o reg %h byte %0d got %h expected %h",
                     test_name, rn, bs, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic wait_idle(input logic [7:0] dly);
        byte_t status_hi;
        status_hi = 8'hFF;
        while (status_hi[STAT_MEM_WAIT-8]) begin
            bus_access(1'b1, XM_SYS_CTRL, 1'b0, 8'h00, dly, status_hi);
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0s: pass, %0d checks", test_name, test_checks);
        end else begin
            $display("test %0s: %0d of %0d checks failed", test_name, test_errors, test_checks);
        end
    endtask

    task automatic start_test(input logic [8*32-1:0] name);
        if (test_open) finish_test();
        test_name   = name;
        test_open   = 1'b1;
        test_errors = 0;
        test_checks = 0;
        test_count++;
    endtask

    task automatic load_trace(output logic ok);
        int              fd;
        logic [8*96-1:0] line;
        ok = 1'b0;
        fd = $fopen("tests/reg_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) > 0) trace_lines.push_back(line);
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    task automatic run_line(input logic [8*96-1:0] line);
        logic [7:0]      ch, op;
        logic [31:0]     rn, bs, val, dly;
        logic [8*32-1:0] name;
        byte_t           got;
        int              n;
        n = $sscanf(line, " %c", ch);
        if (n < 1 || ch == "/") begin
            n = 0;                         // blank or column comment
        end else if (ch == "#") begin
            n = $sscanf(line, " # %s", name);
            start_test(name);
        end else begin
            n = $sscanf(line, " %c %h %h %h %d", op, rn, bs, val, dly);
            if (n != 5 || !(op == "W" || op == "R" || op == "I")) begin
                $display("trace line could not be parsed: %0s", line);
                error_count++;
                test_errors++;
            end else if (op == "W") begin
                bus_access(1'b0, rn[3:0], bs[0], val[7:0], dly[7:0], got);
            end else if (op == "R") begin
                bus_access(1'b1, rn[3:0], bs[0], 8'h00, dly[7:0], got);
                check_byte(rn[3:0], bs[0], got, val[7:0]);
            end else begin
                wait_idle(dly[7:0]);
            end
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        cs_n        = 1'b1;
        rd_nwr      = 1'b1;
        reg_num     = '0;
        bytesel     = 1'b0;
        bus_wdata   = '0;
        h_blank     = 1'b0;
        v_blank     = 1'b0;
        ack_delay   = 8'd3;
        cycle_count = 0;
        cycle_limit = 0;
        test_open   = 1'b0;
        test_name   = "none";
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        test_errors = 0;
        test_checks = 0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("could not open the trace file tests/reg_trace.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            cycle_limit = trace_lines.size() * CYCLES_PER_LINE;
            repeat (2) @(posedge clk);
            #5;
            reset_i = 1'b0;
            foreach (trace_lines[i]) run_line(trace_lines[i]);
            if (test_open) finish_test();
            $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
            if (error_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/reg_trace.txt
// op reg bytesel value delay: op W writes, R reads and expects, I waits for idle
// reg, bytesel and value in hex, delay is the memory ack delay in cycles
# reset_values
R 0 0 00 3
R 0 1 0f 3
R 6 1 00 3
R 7 0 00 3
R 8 1 00 3
R 9 0 00 3
R 3 1 00 3
R 4 0 00 3
R 1 1 00 3
R 2 0 00 3
R d 1 00 3
# register_readback
W 6 0 12 3
W 6 1 34 3
R 6 0 12 3
R 6 1 34 3
W 8 0 00 3
W 8 1 02 3
R 8 1 02 3
W 9 0 00 3
W 9 1 10 3
R 9 0 00 3
R 9 1 10 3
W 4 0 00 3
W 4 1 20 3
R 4 1 20 3
W 2 0 55 3
W 1 1 aa 3
R 2 0 00 3
R 1 1 00 3
# vram_write_step
W 0 1 0a 3
R 0 1 0a 3
W 0 1 0f 3
W a 0 be 3
W a 1 ef 3
W b 0 ca 3
W b 1 fe 3
R 9 0 00 3
R 9 1 14 3
# vram_preread
W 6 0 00 3
W 6 1 02 3
W 7 0 00 3
W 7 1 10 3
R a 0 be 3
R a 1 ef 3
R b 0 ca 3
R b 1 fe 3
R 7 1 16 3
R a 0 00 3
# xr_path
W 5 0 12 3
W 5 1 34 3
W 5 0 56 3
W 5 1 78 3
R 4 1 22 3
W 3 0 00 3
W 3 1 20 3
R 5 0 12 3
R 5 1 34 3
R 5 0 56 3
R 5 1 78 3
R 3 1 23 3
# busy_flag
W a 0 11 20
W a 1 22 20
R 0 0 80 20
I 0 0 00 20
R 0 0 00 3
R 9 1 16 3

// File: filelist.f
hw/xm_types_pkg.sv
hw/xm_regmap_pkg.sv
hw/bus_strobe_sync.sv
hw/vram_channel.sv
hw/xr_channel.sv
hw/reg_read_mux.sv
hw/xm_reg_interface.sv
tests/tb_mem_model.sv
tests/tb_reg_interface.sv
